/* design/usb3_descramble.sv */
// output stage, applies the keystream to data lanes of realigned words
// K lanes pass through untouched, com lanes restart the lfsr
// the lfsr keeps running while scr_enable is low
// output registered one cycle after coll_valid, zero when idle
`default_nettype none
`timescale 1ns/100ps

module usb3_descramble #(
	parameter logic [15:0] SCR_SEED = usb3_rx_pkg::LFSR_SEED_DEFAULT
) (
	input  wire                     local_clk,
	input  wire                     reset_n,
	input  logic                    scr_enable,
	input  logic                    coll_valid,
	input  usb3_rx_pkg::sym_word_t  coll,
	output logic                    proc_valid,
	output usb3_rx_pkg::sym_word_t  proc_word
);

	logic [3:0]  com_mask;
	logic [31:0] key;
	usb3_rx_pkg::sym_word_t plain;

	// K28.5 lanes of the incoming word
	always_comb begin
		for (int i = 0; i < 4; i++) begin
			com_mask[i] = coll.datak[i] &&
				(coll.data[8*i +: 8] == usb3_rx_pkg::SYM_K_COM);
		end
	end

	// one lfsr step per realigned word
	usb3_lfsr #(
		.SCR_SEED (SCR_SEED)
	) usb3_lfsr_inst (
		.local_clk (local_clk),
		.reset_n   (reset_n),
		.step      (coll_valid),
		.com_mask  (com_mask),
		.key       (key)
	);

	// xor only data lanes, and only when enabled
	always_comb begin
		plain.datak = coll.datak;
		for (int i = 0; i < 4; i++) begin
			plain.data[8*i +: 8] = coll.data[8*i +: 8] ^
				((scr_enable && !coll.datak[i]) ? key[8*i +: 8] : 8'h00);
		end
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n)
			proc_valid <= 1'b0;
		else
			proc_valid <= coll_valid;
	end

	// squelch between words
	always_ff @(posedge local_clk) begin
		proc_word <= coll_valid ? plain : '0;
	end

endmodule

`default_nettype wire

/* design/usb3_lfsr.sv */
// usb 3.0 scrambler lfsr, four keystream bytes per word
// key bytes are combinational from the stored state and com_mask
// a com lane reloads SCR_SEED, gets key zero and does not advance
// every other lane takes the upper state byte, then eight shifts
// state is only stored when step is high
`default_nettype none
`timescale 1ns/100ps

module usb3_lfsr #(
	parameter logic [15:0] SCR_SEED = usb3_rx_pkg::LFSR_SEED_DEFAULT
) (
	input  wire         local_clk,
	input  wire         reset_n,
	input  logic        step,
	input  logic [3:0]  com_mask,
	output logic [31:0] key
);

	logic [15:0] state;
	logic [15:0] lane_state;
	logic [15:0] next_state;

	// eight galois shifts, one per scrambled bit
	function automatic logic [15:0] adv8(input logic [15:0] s);
		logic [15:0] r;
		r = s;
		for (int b = 0; b < 8; b++) begin
			r = {r[14:0], 1'b0} ^ (r[15] ? usb3_rx_pkg::LFSR_TAPS : 16'h0000);
		end
		return r;
	endfunction

	// walk lanes 0 to 3 in time order
	always_comb begin
		lane_state = state;
		for (int i = 0; i < 4; i++) begin
			if (com_mask[i]) begin
				// restart from this lane onward
				lane_state = SCR_SEED;
				key[8*i +: 8] = 8'h00;
			end else begin
				key[8*i +: 8] = lane_state[15:8];
				lane_state = adv8(lane_state);
			end
		end
		// state that follows lane 3
		next_state = lane_state;
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n)
			state <= SCR_SEED;
		else if (step)
			state <= next_state;
	end

endmodule

`default_nettype wire

/* design/usb3_rx_pkg.sv */
// shared symbol constants and types for the usb 3.0 rx symbol path
// four 8-bit symbols per word, lane 0 (bits 7:0) is first in time
// only the K28.1 skp and K28.5 com values are known here
// lfsr is kept in galois form, the msb leaves the register first
`default_nettype none

package usb3_rx_pkg;

	// K28.1, skip ordered-set symbol
	localparam logic [7:0] SYM_K_SKP = 8'h3C;

	// K28.5, comma, restarts the scrambler
	localparam logic [7:0] SYM_K_COM = 8'hBC;

	// x^16 + x^5 + x^4 + x^3 + 1
	// bit 15 shifts out and is folded back into bits 5, 4, 3 and 0
	localparam logic [15:0] LFSR_TAPS = 16'h0039;

	// scrambler state after reset and after every com
	localparam logic [15:0] LFSR_SEED_DEFAULT = 16'hFFFF;

	// one raw or processed word
	// datak[i] marks data[8*i +: 8] as a K symbol
	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  datak;
	} sym_word_t;

	// survivors of one word after skp removal
	// packed from lane 0 upward, lanes at and above count are zero
	typedef struct packed {
		sym_word_t  word;
		logic [2:0] count;
	} sym_frag_t;

endpackage

`default_nettype wire

/* design/usb3_rx_top.sv */
// usb 3.0 rx symbol path: skp removal, realign, descramble
// single clock domain, no back-pressure, output never outruns input
// err_skp_unexpected is sticky until reset
`default_nettype none
`timescale 1ns/100ps

module usb3_rx_top #(
	parameter logic [15:0] SCR_SEED = usb3_rx_pkg::LFSR_SEED_DEFAULT
) (
	input  wire                     local_clk,
	input  wire                     reset_n,
	input  logic                    rx_valid,
	input  usb3_rx_pkg::sym_word_t  rx_word,
	input  logic                    scr_enable,
	output logic                    proc_valid,
	output usb3_rx_pkg::sym_word_t  proc_word,
	output logic                    err_skp_unexpected
);

	// skp_strip to word_realign
	logic                   frag_valid;
	usb3_rx_pkg::sym_frag_t frag;
	// word_realign to descramble
	logic                   coll_valid;
	usb3_rx_pkg::sym_word_t coll;

	usb3_skp_strip usb3_skp_strip_inst (
		.local_clk          (local_clk),
		.reset_n            (reset_n),
		.rx_valid           (rx_valid),
		.rx_word            (rx_word),
		.frag_valid         (frag_valid),
		.frag               (frag),
		.err_skp_unexpected (err_skp_unexpected)
	);

	usb3_word_realign usb3_word_realign_inst (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.frag_valid (frag_valid),
		.frag       (frag),
		.coll_valid (coll_valid),
		.coll       (coll)
	);

	usb3_descramble #(
		.SCR_SEED (SCR_SEED)
	) usb3_descramble_inst (
		.local_clk  (local_clk),
		.reset_n    (reset_n),
		.scr_enable (scr_enable),
		.coll_valid (coll_valid),
		.coll       (coll),
		.proc_valid (proc_valid),
		.proc_word  (proc_word)
	);

endmodule

`default_nettype wire

/* design/usb3_skp_strip.sv */
// removes skp symbols from the raw phy word and compacts what is left
// skp lanes must form a single contiguous run inside one word
// any other skp pattern drops the whole word and sets a sticky error
// output is registered, exactly one cycle after rx_valid
`default_nettype none
`timescale 1ns/100ps

module usb3_skp_strip (
	input  wire                     local_clk,
	input  wire                     reset_n,
	input  logic                    rx_valid,
	input  usb3_rx_pkg::sym_word_t  rx_word,
	output logic                    frag_valid,
	output usb3_rx_pkg::sym_frag_t  frag,
	output logic                    err_skp_unexpected
);

	// lanes holding a K28.1
	logic [3:0] skip;
	// first lane of each skp run
	logic [3:0] run_start;
	logic       legal;
	// survivors count, also the write pointer while compacting
	logic [2:0] idx;
	usb3_rx_pkg::sym_word_t packed_word;

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			skip[i] = rx_word.datak[i] &&
				(rx_word.data[8*i +: 8] == usb3_rx_pkg::SYM_K_SKP);
		end
	end

	// a run starts where skp follows a non-skp lane (or lane 0)
	assign run_start = skip & ~{skip[2:0], 1'b0};

	// zero or one run start means the pattern is legal
	assign legal = ((run_start & (run_start - 4'd1)) == 4'd0);

	// shift survivors down into lane order, upper lanes stay zero
	always_comb begin
		idx = 3'd0;
		packed_word = '0;
		for (int i = 0; i < 4; i++) begin
			if (!skip[i]) begin
				packed_word.data[8*idx[1:0] +: 8] = rx_word.data[8*i +: 8];
				packed_word.datak[idx[1:0]] = rx_word.datak[i];
				idx = idx + 3'd1;
			end
		end
	end

	// control, strobe follows input strobe one to one
	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			frag_valid <= 1'b0;
			err_skp_unexpected <= 1'b0;
		end else begin
			frag_valid <= rx_valid;
			// sticky until reset
			if (rx_valid && !legal)
				err_skp_unexpected <= 1'b1;
		end
	end

	// payload, illegal word becomes an empty fragment
	always_ff @(posedge local_clk) begin
		frag.word <= legal ? packed_word : '0;
		frag.count <= legal ? idx : 3'd0;
	end

endmodule

`default_nettype wire

/* design/usb3_word_realign.sv */
// packs variable-size fragments back into full four-symbol words
// 7-symbol accumulator, oldest symbol sits in lane 0
// four symbols leave in the cycle after depth reaches four
// the append of the current fragment happens in that same cycle
// depth cannot pass seven since at most four come in per cycle
`default_nettype none
`timescale 1ns/100ps

module usb3_word_realign (
	input  wire                     local_clk,
	input  wire                     reset_n,
	input  logic                    frag_valid,
	input  usb3_rx_pkg::sym_frag_t  frag,
	output logic                    coll_valid,
	output usb3_rx_pkg::sym_word_t  coll
);

	// held symbols, lane i at bits 8*i +: 8
	logic [55:0] acc_data;
	logic [6:0]  acc_datak;
	logic [2:0]  depth;

	logic        take;
	logic [2:0]  keep;
	logic [2:0]  add;
	logic [2:0]  lane;
	logic [55:0] base_data;
	logic [6:0]  base_datak;
	logic [55:0] next_data;
	logic [6:0]  next_datak;
	logic [2:0]  next_depth;

	always_comb begin
		// a full word is present, it goes out now
		take = (depth >= 3'd4);
		keep = take ? depth - 3'd4 : depth;
		add = frag_valid ? frag.count : 3'd0;
		// drop the outgoing word from the bottom
		base_data = take ? {32'd0, acc_data[55:32]} : acc_data;
		base_datak = take ? {4'd0, acc_datak[6:4]} : acc_datak;
		next_data = '0;
		next_datak = '0;
		lane = 3'd0;
		// held symbols first, new fragment right behind them
		for (int i = 0; i < 7; i++) begin
			lane = 3'(i) - keep;
			if (3'(i) < keep) begin
				next_data[8*i +: 8] = base_data[8*i +: 8];
				next_datak[i] = base_datak[i];
			end else if (3'(i) < keep + add) begin
				next_data[8*i +: 8] = frag.word.data[8*lane[1:0] +: 8];
				next_datak[i] = frag.word.datak[lane[1:0]];
			end
		end
		next_depth = keep + add;
	end

	always_ff @(posedge local_clk) begin
		if (!reset_n) begin
			depth <= 3'd0;
			coll_valid <= 1'b0;
		end else begin
			depth <= next_depth;
			coll_valid <= take;
		end
	end

	// payload, symbols above depth are kept at zero
	always_ff @(posedge local_clk) begin
		acc_data <= next_data;
		acc_datak <= next_datak;
		coll.data <= acc_data[31:0];
		coll.datak <= acc_datak[3:0];
	end

endmodule

`default_nettype wire

/* flist.f */
design/usb3_rx_pkg.sv
design/usb3_skp_strip.sv
design/usb3_word_realign.sv
design/usb3_lfsr.sv
design/usb3_descramble.sv
design/usb3_rx_top.sv
test/tb_usb3_rx.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the usb3 rx testbench with verilator
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/100ps -f flist.f \
	--top-module tb_usb3_rx -o tb_usb3_rx &&
./obj_dir/tb_usb3_rx || { echo "simulation did not pass"; exit 1; }

/* test/tb_usb3_rx.sv */
// testbench for the usb 3.0 rx symbol path
// stimulus comes from a galois lfsr with seed 55 stepped once per bit taken
// scr_enable may change while words are in flight, so the monitor applies
// the value seen in the cycle before proc_valid
// leftover symbols (fewer than four) stay in the accumulator and are not checked
`default_nettype none
`timescale 1ns/100ps

module tb_usb3_rx;

	// one expected output symbol and the key meant for it
	typedef struct packed {
		logic [7:0] data;
		logic       k;
		logic [7:0] key;
	} exp_sym_t;

	// non-standard scrambler seed passed down to the lfsr
	localparam logic [15:0] SEED = 16'h1D2B;
	// non-contiguous skp lane patterns
	localparam logic [19:0] BAD_MASKS = {4'b0101, 4'b1001, 4'b1010, 4'b1011, 4'b1101};

	logic                   local_clk;
	logic                   reset_n;
	logic                   rx_valid;
	usb3_rx_pkg::sym_word_t rx_word;
	logic                   scr_enable;
	logic                   proc_valid;
	usb3_rx_pkg::sym_word_t proc_word;
	logic                   err_skp_unexpected;

	logic [15:0] prng_state = 16'd55;
	// keystream position of the model as it walks symbols in arrival order
	logic [15:0] model_state = SEED;
	logic        scr_prev = 1'b1;
	exp_sym_t    exp_q[$];

	usb3_rx_top #(
		.SCR_SEED (SEED)
	) usb3_rx_top_inst (
		.local_clk          (local_clk),
		.reset_n            (reset_n),
		.rx_valid           (rx_valid),
		.rx_word            (rx_word),
		.scr_enable         (scr_enable),
		.proc_valid         (proc_valid),
		.proc_word          (proc_word),
		.err_skp_unexpected (err_skp_unexpected)
	);

	initial begin
		local_clk = 1'b0;
		forever #4 local_clk = ~local_clk;
	end

	task automatic stop_with_fail(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp)
			stop_with_fail($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
	endtask

	// right-shift galois lfsr where the bit shifted out is the bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			r = {r[30:0], prng_state[0]};
			prng_state = {1'b0, prng_state[15:1]} ^ (prng_state[0] ? 16'hB400 : 16'h0000);
		end
		return r;
	endfunction

	// x^16+x^5+x^4+x^3+1 where the msb leaves and comes back at bits 0, 3, 4, 5
	function automatic logic [15:0] scr_advance(input logic [15:0] s);
		logic [15:0] r;
		logic        fb;
		r = s;
		for (int b = 0; b < 8; b++) begin
			fb = r[15];
			r = r << 1;
			r[0] = fb;
			r[3] = r[3] ^ fb;
			r[4] = r[4] ^ fb;
			r[5] = r[5] ^ fb;
		end
		return r;
	endfunction

	// expected symbols of one input word in arrival order
	function automatic void ref_model(input usb3_rx_pkg::sym_word_t w);
		logic [3:0] skp;
		logic       prev;
		int         starts;
		exp_sym_t   e;
		prev = 1'b0;
		starts = 0;
		for (int i = 0; i < 4; i++) begin
			skp[i] = w.datak[i] && (w.data[8*i +: 8] == usb3_rx_pkg::SYM_K_SKP);
			if (skp[i] && !prev)
				starts++;
			prev = skp[i];
		end
		// more than one skp run loses the whole word
		if (starts > 1)
			return;
		for (int i = 0; i < 4; i++) begin
			if (!skp[i]) begin
				e.data = w.data[8*i +: 8];
				e.k = w.datak[i];
				if (e.k && e.data == usb3_rx_pkg::SYM_K_COM) begin
					model_state = SEED;
					e.key = 8'h00;
				end else begin
					e.key = model_state[15:8];
					model_state = scr_advance(model_state);
				end
				exp_q.push_back(e);
			end
		end
	endfunction

	// random data with skp in the masked lanes and com plus a K28.7 two lanes on
	function automatic usb3_rx_pkg::sym_word_t build_word(input logic [3:0] skp_mask,
			input int com_lane);
		usb3_rx_pkg::sym_word_t w;
		w.data = rand_bits(32);
		w.datak = skp_mask;
		for (int i = 0; i < 4; i++) begin
			if (skp_mask[i])
				w.data[8*i +: 8] = usb3_rx_pkg::SYM_K_SKP;
		end
		if (com_lane >= 0) begin
			w.data[8*com_lane +: 8] = usb3_rx_pkg::SYM_K_COM;
			w.datak[com_lane] = 1'b1;
			w.data[8*((com_lane + 2) % 4) +: 8] = 8'hFC;
			w.datak[(com_lane + 2) % 4] = 1'b1;
		end
		return w;
	endfunction

	task automatic send_word(input usb3_rx_pkg::sym_word_t w);
		@(posedge local_clk);
		rx_valid <= 1'b1;
		rx_word <= w;
		ref_model(w);
	endtask

	// junk on the bus while rx_valid is low
	task automatic idle_cycle();
		@(posedge local_clk);
		rx_valid <= 1'b0;
		rx_word.data <= rand_bits(32);
		rx_word.datak <= 4'(rand_bits(4));
	endtask

	// scoreboard samples outputs mid-cycle
	always @(negedge local_clk) begin
		usb3_rx_pkg::sym_word_t exp_word;
		exp_sym_t               e;
		if (reset_n && proc_valid === 1'b1) begin
			if (exp_q.size() < 4) begin
				stop_with_fail("an output word appeared with no expected word left");
			end else begin
				for (int i = 0; i < 4; i++) begin
					e = exp_q.pop_front();
					exp_word.data[8*i +: 8] = e.data ^ ((scr_prev && !e.k) ? e.key : 8'h00);
					exp_word.datak[i] = e.k;
				end
				compare_value("proc_word.data", 64'(proc_word.data), 64'(exp_word.data));
				compare_value("proc_word.datak", 64'(proc_word.datak), 64'(exp_word.datak));
			end
		end
		// value that the descrambler uses for the word seen next cycle
		scr_prev = scr_enable;
	end

	initial begin
		logic [3:0] m;
		int         t;
		reset_n = 1'b0;
		rx_valid = 1'b0;
		rx_word = '0;
		scr_enable = 1'b1;
		repeat (16) @(posedge local_clk);
		reset_n <= 1'b1;
		// quiet window after reset
		repeat (32) begin
			@(negedge local_clk);
			compare_value("proc_valid", 64'(proc_valid), 64'h0);
			compare_value("err_skp_unexpected", 64'(err_skp_unexpected), 64'h0);
		end
		// back-to-back data words
		repeat (24) send_word(build_word(4'h0, -1));
		idle_cycle();
		// every legal skp run with idles and all-skp words mixed in
		repeat (2) begin
			for (int s = 0; s < 4; s++) begin
				for (int n = 1; n <= 4 - s; n++) begin
					m = 4'(((1 << n) - 1) << s);
					send_word(build_word(m, -1));
					if (rand_bits(2) == 0)
						idle_cycle();
					if (rand_bits(3) == 0)
						send_word(build_word(4'hF, -1));
				end
			end
		end
		// com in each lane with a whole number of words per group
		// so each pass puts com in all four output lanes
		// a single skp between passes shifts the alignment
		repeat (2) begin
			for (int c = 0; c < 4; c++) begin
				send_word(build_word(4'h0, c));
				repeat (2) send_word(build_word(4'h0, -1));
			end
			send_word(build_word(4'(1 << rand_bits(2)), -1));
		end
		// descrambler off mid-stream and then back on
		scr_enable <= 1'b0;
		repeat (10) send_word(build_word(4'(1 << rand_bits(2)), -1));
		scr_enable <= 1'b1;
		repeat (10) send_word(build_word(4'h0, -1));
		idle_cycle();
		@(negedge local_clk);
		compare_value("err_skp_unexpected", 64'(err_skp_unexpected), 64'h0);
		// illegal skp patterns drop their word while later words still match
		for (int b = 0; b < 5; b++) begin
			send_word(build_word(BAD_MASKS[4*b +: 4], -1));
			repeat (3) send_word(build_word(4'h0, -1));
		end
		idle_cycle();
		for (t = 0; t < 8 && err_skp_unexpected !== 1'b1; t++)
			@(negedge local_clk);
		compare_value("err_skp_unexpected", 64'(err_skp_unexpected), 64'h1);
		// wait for all full words to come out
		for (t = 0; t < 64 && exp_q.size() >= 4; t++)
			@(posedge local_clk);
		if (exp_q.size() >= 4) begin
			stop_with_fail("timeout: expected output words never appeared");
		end else begin
			repeat (8) @(negedge local_clk);
			compare_value("err_skp_unexpected", 64'(err_skp_unexpected), 64'h1);
			$display("** PASS **");
			$finish;
		end
	end

endmodule

`default_nettype wire
